// File: hdl/link_pkg.sv
/*
 * link package
 * frame codes and frame geometry of the one-wire handshake line
 */
package link_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // code carried by one frame, msb goes out first
    typedef logic [1:0] frame_code_t;

    // ack, used for ready and for acknowledging a game end
    localparam frame_code_t CODE_ACK = 2'b01;
    // game end, sent by the losing side
    localparam frame_code_t CODE_END = 2'b10;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // start bit, two code bits, stop bit
    localparam int   FRAME_BITS = 4;
    localparam logic START_BIT  = 1'b1;
    localparam logic STOP_BIT   = 1'b0;
    // quiet line sits at the same level as the stop bit
    localparam logic IDLE_BIT   = 1'b0;

endpackage

// File: hdl/game_pkg.sv
/*
 * game package
 * session state encoding and win timeout of the multiplayer link
 */
package game_pkg;

    // multiplayer session states
    typedef enum logic [2:0] {
        IDLE,
        GAME_READY,
        IN_GAME,
        GAME_LOST,
        GAME_WON
    } session_state_t;

    // cycles spent in GAME_WON before going back to idle
    localparam int WIN_TIMEOUT_CYCLES = 64;
    // counter width, must hold WIN_TIMEOUT_CYCLES - 1
    localparam int WIN_COUNT_BITS     = 7;

endpackage

// File: hdl/win_timer.sv
/*
 * win timer
 * counts cycles while enabled and flags the end of the win window
 */
`timescale 1ns/1ps

module win_timer (
    input  logic clk,
    input  logic rst_l,
    input  logic enable,
    output logic timeout
);
    import game_pkg::*;

    logic [WIN_COUNT_BITS-1:0] win_cnt;

    // counter restarts from zero every time enable drops
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            win_cnt <= '0;
        end else if (!enable) begin
            win_cnt <= '0;
        end else begin
            win_cnt <= win_cnt + 1'b1;
        end
    end

    // terminal count, the fsm leaves on the following edge
    assign timeout = enable && (win_cnt == WIN_COUNT_BITS'(WIN_TIMEOUT_CYCLES - 1));

endmodule

// File: hdl/sender_fsm.sv
/*
 * session control FSM
 * tracks the multiplayer session, picks which frames to send
 * and reports the game status to the game logic
 */
`timescale 1ns/1ps

module sender_fsm (
    input  logic clk,
    input  logic rst_l,
    input  logic player_ready,
    input  logic player_unready,
    input  logic top_out,
    input  logic ack_received,
    input  logic game_end,
    output logic send_ready,
    output logic send_game_lost,
    output logic game_active,
    output logic ingame,
    output logic gamelost
);
    import game_pkg::*;

    session_state_t state;
    session_state_t next_state;
    logic           win_en;
    logic           win_timeout;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // win window
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // timer only runs in GAME_WON, cleared everywhere else
    assign win_en = (state == GAME_WON);

    win_timer win_timer_inst (
        .clk     (clk),
        .rst_l   (rst_l),
        .enable  (win_en),
        .timeout (win_timeout)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // next state
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // wait for the player to ask for a match
                if (player_ready) begin
                    next_state = GAME_READY;
                end
            end
            GAME_READY: begin
                // cancel wins over an ack arriving the same cycle
                if (player_unready) begin
                    next_state = IDLE;
                end else if (ack_received) begin
                    next_state = IN_GAME;
                end
            end
            IN_GAME: begin
                // opponent's game end takes priority over our own top out
                if (game_end) begin
                    next_state = GAME_WON;
                end else if (top_out) begin
                    next_state = GAME_LOST;
                end
            end
            GAME_LOST: begin
                // opponent acknowledges our game end
                if (ack_received) begin
                    next_state = IDLE;
                end
            end
            GAME_WON: begin
                if (win_timeout) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        send_ready     = 1'b0;
        send_game_lost = 1'b0;
        game_active    = 1'b0;
        ingame         = 1'b0;
        gamelost       = 1'b0;
        case (state)
            GAME_READY: begin
                // keep offering acks until the opponent answers
                send_ready  = 1'b1;
                game_active = 1'b1;
            end
            IN_GAME: begin
                game_active = 1'b1;
                ingame      = 1'b1;
            end
            GAME_LOST: begin
                // repeat game end until acknowledged
                send_game_lost = 1'b1;
                game_active    = 1'b1;
                gamelost       = 1'b1;
            end
            GAME_WON: begin
                // acks let the losing side drop back to idle
                send_ready  = 1'b1;
                game_active = 1'b1;
            end
            default: begin
                send_ready = 1'b0;
            end
        endcase
    end

endmodule

// File: hdl/handshake_tx.sv
/*
 * handshake transmitter
 * serializes ack and game end frames onto the outgoing line
 */
`timescale 1ns/1ps

module handshake_tx (
    input  logic clk,
    input  logic rst_l,
    input  logic send_ready,
    input  logic send_game_lost,
    output logic link_out
);
    import link_pkg::*;

    logic        busy;
    logic [1:0]  bit_cnt;
    frame_code_t frame_code;
    logic        frame_done;
    logic        frame_req;

    // boundary is either a quiet line or the stop bit going out
    assign frame_done = !busy || (bit_cnt == 2'(FRAME_BITS - 1));
    // requests are levels, only looked at on a boundary
    assign frame_req  = send_ready || send_game_lost;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bit sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // bit_cnt is the index of the bit currently on link_out
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            link_out <= IDLE_BIT;
        end else if (frame_done) begin
            // start a new frame right away, or go quiet
            busy     <= frame_req;
            bit_cnt  <= '0;
            link_out <= frame_req ? START_BIT : IDLE_BIT;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
            case (bit_cnt)
                2'd0: begin
                    link_out <= frame_code[1];
                end
                2'd1: begin
                    link_out <= frame_code[0];
                end
                default: begin
                    link_out <= STOP_BIT;
                end
            endcase
        end
    end

    // code latched with the start bit, held for the whole frame
    always_ff @(posedge clk) begin
        if (frame_done) begin
            frame_code <= send_game_lost ? CODE_END : CODE_ACK;
        end
    end

endmodule

// File: hdl/handshake_rx.sv
/*
 * handshake receiver
 * detects frames on the incoming line and pulses ack_received
 * or game_end for one cycle per valid frame
 */
`timescale 1ns/1ps

module handshake_rx (
    input  logic clk,
    input  logic rst_l,
    input  logic link_in,
    output logic ack_received,
    output logic game_end
);
    import link_pkg::*;

    // hunt for start, take two code bits, skip the stop bit
    typedef enum logic [1:0] {
        RX_HUNT,
        RX_CODE_HI,
        RX_CODE_LO,
        RX_STOP
    } rx_state_t;

    rx_state_t   rx_state;
    logic        link_q;
    frame_code_t code_sr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input stage and frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            link_q   <= IDLE_BIT;
            rx_state <= RX_HUNT;
        end else begin
            link_q <= link_in;
            case (rx_state)
                RX_HUNT: begin
                    if (link_q == START_BIT) begin
                        rx_state <= RX_CODE_HI;
                    end
                end
                RX_CODE_HI: begin
                    rx_state <= RX_CODE_LO;
                end
                RX_CODE_LO: begin
                    rx_state <= RX_STOP;
                end
                default: begin
                    // stop bit is not checked, back to hunting
                    rx_state <= RX_HUNT;
                end
            endcase
        end
    end

    // msb arrives first, shift left
    always_ff @(posedge clk) begin
        if ((rx_state == RX_CODE_HI) || (rx_state == RX_CODE_LO)) begin
            code_sr <= {code_sr[0], link_q};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // code decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // RX_STOP lasts one cycle so each frame gives exactly one pulse,
    // three cycles after the start bit was registered
    // unknown codes match neither compare and are dropped
    assign ack_received = (rx_state == RX_STOP) && (code_sr == CODE_ACK);
    assign game_end     = (rx_state == RX_STOP) && (code_sr == CODE_END);

endmodule

// File: hdl/multiplayer_link.sv
/*
 * multiplayer link top
 * session FSM plus the handshake transmitter and receiver
 */
`timescale 1ns/1ps

module multiplayer_link (
    input  logic clk,
    input  logic rst_l,
    input  logic player_ready,
    input  logic player_unready,
    input  logic top_out,
    input  logic link_in,
    output logic link_out,
    output logic game_active,
    output logic ingame,
    output logic gamelost
);

    // frame requests from the fsm, levels
    logic send_ready;
    logic send_game_lost;
    // decoded opponent frames, one-cycle pulses
    logic ack_received;
    logic game_end;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // session control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    sender_fsm sender_fsm_inst (
        .clk            (clk),
        .rst_l          (rst_l),
        .player_ready   (player_ready),
        .player_unready (player_unready),
        .top_out        (top_out),
        .ack_received   (ack_received),
        .game_end       (game_end),
        .send_ready     (send_ready),
        .send_game_lost (send_game_lost),
        .game_active    (game_active),
        .ingame         (ingame),
        .gamelost       (gamelost)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake line
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // outgoing line toward the opponent
    handshake_tx handshake_tx_inst (
        .clk            (clk),
        .rst_l          (rst_l),
        .send_ready     (send_ready),
        .send_game_lost (send_game_lost),
        .link_out       (link_out)
    );

    // incoming line from the opponent
    handshake_rx handshake_rx_inst (
        .clk          (clk),
        .rst_l        (rst_l),
        .link_in      (link_in),
        .ack_received (ack_received),
        .game_end     (game_end)
    );

endmodule

// File: verification/multiplayer_link_checker.sv
/*
 * multiplayer link checker
 * concurrent assertions on the status and line outputs of the top level
 */
`timescale 1ns/1ps

module multiplayer_link_checker (
    input logic clk,
    input logic rst_l,
    input logic link_out,
    input logic game_active,
    input logic ingame,
    input logic gamelost
);

    // outgoing line stays quiet while reset is held
    reset_line_quiet: assert property (@(posedge clk) !rst_l |-> !link_out)
        else $error("link_out high while rst_l is low");

    // playing always implies an active session
    ingame_is_active: assert property (@(posedge clk) disable iff (!rst_l)
        ingame |-> game_active)
        else $error("ingame high without game_active");

    // a lost game is no longer in progress
    ingame_not_lost: assert property (@(posedge clk) disable iff (!rst_l)
        !(ingame && gamelost))
        else $error("ingame and gamelost high together");

endmodule

// File: verification/multiplayer_link_tb.sv
/*
 * multiplayer link testbench
 * plays the opponent and the game logic, models the session
 * and compares the DUT status on every rising edge
 */
`timescale 1ns/1ps

module multiplayer_link_tb;
    import link_pkg::*;
    import game_pkg::*;

    logic clk;
    logic rst_l;
    logic player_ready;
    logic player_unready;
    logic top_out;
    logic link_in;
    logic link_out;
    logic game_active;
    logic ingame;
    logic gamelost;

    // scoreboard and model state
    logic           run_checks;
    int             err_cnt;
    int             check_cnt;
    int             test_cnt;
    int             cycle_cnt;
    int             won_cnt;
    int             ev_cycle[$];
    frame_code_t    ev_code[$];
    logic           ev_ack;
    logic           ev_end;
    session_state_t model_state;
    session_state_t model_next;
    logic [2:0]     exp_status;
    logic [31:0]    lfsr_state;
    // line monitor
    int             mon_left;
    frame_code_t    mon_code;
    int             last_start;
    int             last_gap;
    int             ack_frames;
    int             end_frames;
    // main sequence
    int             err_before;
    int             t_won;
    int             pick;
    int             val;
    int             i;

    multiplayer_link multiplayer_link_inst (
        .clk            (clk),
        .rst_l          (rst_l),
        .player_ready   (player_ready),
        .player_unready (player_unready),
        .top_out        (top_out),
        .link_in        (link_in),
        .link_out       (link_out),
        .game_active    (game_active),
        .ingame         (ingame),
        .gamelost       (gamelost)
    );

    bind multiplayer_link multiplayer_link_checker checker_inst (
        .clk         (clk),
        .rst_l       (rst_l),
        .link_out    (link_out),
        .game_active (game_active),
        .ingame      (ingame),
        .gamelost    (gamelost)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // status is {game_active, ingame, gamelost} of the current state
    function automatic void session_model(
        input  session_state_t st,
        input  logic           rdy,
        input  logic           unrdy,
        input  logic           top,
        input  logic           ack,
        input  logic           gend,
        input  logic           win_done,
        output session_state_t nxt,
        output logic [2:0]     status
    );
        nxt    = st;
        status = 3'b000;
        case (st)
            IDLE: begin
                if (rdy) begin
                    nxt = GAME_READY;
                end
            end
            GAME_READY: begin
                status = 3'b100;
                // cancel beats an ack in the same cycle
                if (unrdy) begin
                    nxt = IDLE;
                end else if (ack) begin
                    nxt = IN_GAME;
                end
            end
            IN_GAME: begin
                status = 3'b110;
                // opponent's end beats our own top out
                if (gend) begin
                    nxt = GAME_WON;
                end else if (top) begin
                    nxt = GAME_LOST;
                end
            end
            GAME_LOST: begin
                status = 3'b101;
                if (ack) begin
                    nxt = IDLE;
                end
            end
            GAME_WON: begin
                status = 3'b100;
                if (win_done) begin
                    nxt = IDLE;
                end
            end
            default: begin
                nxt = IDLE;
            end
        endcase
    endfunction

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA3000000;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output int bits);
        int b;
        bits = 0;
        for (b = 0; b < n; b++) begin
            bits = (bits << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // opponent frame, rx pulse expected at the fsm four edges after start
    task automatic send_frame(input frame_code_t code);
        @(negedge clk);
        ev_cycle.push_back(cycle_cnt + 4);
        ev_code.push_back(code);
        link_in = START_BIT;
        @(negedge clk);
        link_in = code[1];
        @(negedge clk);
        link_in = code[0];
        @(negedge clk);
        link_in = STOP_BIT;
    endtask

    // 0 ready, 1 unready, 2 top out, one cycle each
    task automatic pulse_input(input int which);
        @(negedge clk);
        player_ready   = (which == 0);
        player_unready = (which == 1);
        top_out        = (which == 2);
        @(negedge clk);
        player_ready   = 1'b0;
        player_unready = 1'b0;
        top_out        = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_status(input logic [2:0] want, input int limit, input string what);
        int n;
        n = 0;
        while ({game_active, ingame, gamelost} != want && n < limit) begin
            @(negedge clk);
            n++;
        end
        if ({game_active, ingame, gamelost} != want) begin
            $display("timeout at %0t: status never reached %s", $time, what);
            err_cnt++;
        end
    endtask

    task automatic wait_frames(input frame_code_t code, input int count, input int limit);
        int base;
        int n;
        base = (code == CODE_END) ? end_frames : ack_frames;
        n = 0;
        while (((code == CODE_END) ? end_frames : ack_frames) < base + count && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (((code == CODE_END) ? end_frames : ack_frames) < base + count) begin
            $display("timeout at %0t: DUT sent too few frames of code %0b", $time, code);
            err_cnt++;
        end
    endtask

    // line counts as quiet after more than one frame length of zeros
    task automatic wait_line_quiet(input int limit);
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet <= FRAME_BITS && n < limit) begin
            @(negedge clk);
            n++;
            quiet = link_out ? 0 : quiet + 1;
        end
        if (quiet <= FRAME_BITS) begin
            $display("timeout at %0t: link_out never went quiet", $time);
            err_cnt++;
        end
    endtask

    task automatic check_line_silent(input int n);
        int base;
        base = ack_frames + end_frames;
        idle_cycles(n);
        check_cnt++;
        if (ack_frames + end_frames != base) begin
            $display("Error at %0t: frame count expected %0d actual %0d", $time, base,
                ack_frames + end_frames);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare and monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // dut outputs still show the state from before this edge
    always @(posedge clk) begin
        if (!rst_l || !run_checks) begin
            model_state = IDLE;
            won_cnt = 0;
        end else begin
            ev_ack = 1'b0;
            ev_end = 1'b0;
            if (ev_cycle.size() > 0 && ev_cycle[0] == cycle_cnt) begin
                ev_ack = (ev_code[0] == CODE_ACK);
                ev_end = (ev_code[0] == CODE_END);
                void'(ev_cycle.pop_front());
                void'(ev_code.pop_front());
            end
            session_model(model_state, player_ready, player_unready, top_out, ev_ack,
                ev_end, won_cnt == WIN_TIMEOUT_CYCLES - 1, model_next, exp_status);
            check_cnt += 3;
            if (game_active !== exp_status[2]) begin
                $display("Error at %0t: game_active expected %0b actual %0b", $time,
                    exp_status[2], game_active);
                err_cnt++;
            end
            if (ingame !== exp_status[1]) begin
                $display("Error at %0t: ingame expected %0b actual %0b", $time,
                    exp_status[1], ingame);
                err_cnt++;
            end
            if (gamelost !== exp_status[0]) begin
                $display("Error at %0t: gamelost expected %0b actual %0b", $time,
                    exp_status[0], gamelost);
                err_cnt++;
            end
            won_cnt = (model_state == GAME_WON) ? won_cnt + 1 : 0;
            model_state = model_next;
        end
        cycle_cnt++;
    end

    // decodes link_out frames, start bit then msb first
    always @(negedge clk) begin
        if (!rst_l || !run_checks) begin
            mon_left = 0;
        end else if (mon_left == 0) begin
            if (link_out == START_BIT) begin
                mon_left = FRAME_BITS - 1;
                if (last_start >= 0) begin
                    last_gap = cycle_cnt - last_start;
                end
                last_start = cycle_cnt;
            end
        end else begin
            if (mon_left > 1) begin
                mon_code = {mon_code[0], link_out};
            end else if (link_out != STOP_BIT) begin
                $display("stop bit missing on link_out at %0t", $time);
                err_cnt++;
            end else if (mon_code == CODE_ACK) begin
                ack_frames = ack_frames + 1;
            end else if (mon_code == CODE_END) begin
                end_frames = end_frames + 1;
            end else begin
                $display("DUT sent an unknown code %0b at %0t", mon_code, $time);
                err_cnt++;
            end
            mon_left = mon_left - 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk = 1'b0;
        rst_l = 1'b0;
        player_ready = 1'b0;
        player_unready = 1'b0;
        top_out = 1'b0;
        link_in = IDLE_BIT;
        run_checks = 1'b0;
        err_cnt = 0;
        check_cnt = 0;
        test_cnt = 0;
        cycle_cnt = 0;
        won_cnt = 0;
        mon_left = 0;
        mon_code = '0;
        last_start = -1;
        last_gap = 0;
        ack_frames = 0;
        end_frames = 0;
        lfsr_state = 32'h752f468c;
        repeat (4) @(negedge clk);
        rst_l = 1'b1;
        run_checks = 1'b1;

        // quiet after reset
        err_before = err_cnt;
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            check_cnt++;
            if ({game_active, ingame, gamelost, link_out} != 4'b0000) begin
                $display("Error at %0t: status and link_out expected 0000 actual %b", $time,
                    {game_active, ingame, gamelost, link_out});
                err_cnt++;
            end
        end
        report_test("after reset", err_before);

        // ready then cancel
        err_before = err_cnt;
        pulse_input(0);
        wait_status(3'b100, 10, "ready");
        wait_frames(CODE_ACK, 3, 40);
        check_cnt++;
        if (last_gap != FRAME_BITS) begin
            $display("Error at %0t: ack frame period expected %0d actual %0d", $time,
                FRAME_BITS, last_gap);
            err_cnt++;
        end
        pulse_input(1);
        wait_status(3'b000, 10, "idle after cancel");
        wait_line_quiet(20);
        check_line_silent(12);
        report_test("ready and cancel", err_before);

        // opponent ack starts the game
        err_before = err_cnt;
        pulse_input(0);
        wait_status(3'b100, 10, "ready");
        send_frame(CODE_ACK);
        wait_status(3'b110, 20, "in game");
        wait_line_quiet(20);
        check_line_silent(12);
        report_test("game start", err_before);

        // top out, opponent acknowledges the end
        err_before = err_cnt;
        pulse_input(2);
        wait_status(3'b101, 10, "lost");
        wait_frames(CODE_END, 2, 40);
        send_frame(CODE_ACK);
        wait_status(3'b000, 20, "idle after loss");
        wait_line_quiet(20);
        report_test("loss", err_before);

        // opponent ends, win window runs out
        err_before = err_cnt;
        pulse_input(0);
        wait_status(3'b100, 10, "ready");
        send_frame(CODE_ACK);
        wait_status(3'b110, 20, "in game");
        send_frame(CODE_END);
        wait_status(3'b100, 20, "won");
        t_won = cycle_cnt;
        wait_frames(CODE_ACK, 2, 40);
        wait_status(3'b000, 2 * WIN_TIMEOUT_CYCLES, "idle after win");
        check_cnt++;
        if (cycle_cnt - t_won != WIN_TIMEOUT_CYCLES) begin
            $display("Error at %0t: win window expected %0d actual %0d", $time,
                WIN_TIMEOUT_CYCLES, cycle_cnt - t_won);
            err_cnt++;
        end
        report_test("win", err_before);

        // random sessions, unknown codes included
        err_before = err_cnt;
        for (i = 0; i < 80; i++) begin
            take_bits(3, pick);
            if (pick < 3) begin
                pulse_input(pick);
            end else if (pick < 6) begin
                take_bits(2, val);
                send_frame(val[1:0]);
            end else begin
                take_bits(3, val);
                idle_cycles(val + 1);
            end
        end
        i = 0;
        while (ev_cycle.size() > 0 && i < 20) begin
            @(negedge clk);
            i++;
        end
        if (ev_cycle.size() > 0) begin
            $display("timeout at %0t: expected receiver pulses never came due", $time);
            err_cnt++;
        end
        idle_cycles(4);
        report_test("random sessions", err_before);

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: multiplayer_link.f
hdl/link_pkg.sv
hdl/game_pkg.sv
hdl/win_timer.sv
hdl/sender_fsm.sv
hdl/handshake_tx.sv
hdl/handshake_rx.sv
hdl/multiplayer_link.sv
verification/multiplayer_link_checker.sv
verification/multiplayer_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the multiplayer link testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module multiplayer_link_tb \
    -f multiplayer_link.f -o sim_multiplayer_link \
    && ./obj_dir/sim_multiplayer_link > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
